// ==== hdl/uart_bridge_pkg.sv ====
package uart_bridge_pkg;

    localparam int PACKET_BYTES   = 9;
    localparam int BANK_SPAN_BITS = 8;       // 256 bytes per bank.

    localparam logic [3:0] OPCODE_WR  = 4'hA;
    localparam logic [3:0] OPCODE_RD  = 4'h5;
    localparam logic [3:0] STATUS_OK  = 4'h0;
    localparam logic [3:0] STATUS_ERR = 4'hF;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Byte k of a frame is bits [8k+7:8k].
    typedef struct packed {
        logic [31:0] data;
        logic [31:0] addr;
        logic [3:0]  opcode;
        logic [3:0]  status;
    } uart_packet_t;

    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        arready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_resp_t;

endpackage

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT) + 1;

    logic [1:0]       sync;
    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_idx;       // 0 start, 1..8 data, 9 stop.
    logic [7:0]       shift;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            sync      <= 2'b11;
            busy      <= 1'b0;
            cnt       <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end
        else
        begin
            sync      <= {sync[0], rxd};
            rx_strobe <= 1'b0;
            if (!busy)
            begin
                if (!sync[1])
                begin
                    busy    <= 1'b1;
                    cnt     <= CNT_W'(CLKS_PER_BIT / 2 - 1); // Aim at mid-bit.
                    bit_idx <= '0;
                end
            end
            else if (cnt != '0)
            begin
                cnt <= cnt - 1'b1;
            end
            else
            begin
                cnt     <= CNT_W'(CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && sync[1])
                begin
                    busy <= 1'b0;                  // Glitch, not a start bit.
                end
                else if (bit_idx == 4'd9)
                begin
                    busy      <= 1'b0;
                    rx_strobe <= sync[1];          // Bad stop bit drops the byte.
                end
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (busy && cnt == '0 && bit_idx >= 4'd1 && bit_idx <= 4'd8)
        begin
            shift <= {sync[1], shift[7:1]};        // LSB arrives first.
        end
    end

    assign rx_byte = shift;

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic [7:0] tx_byte,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       txd
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT) + 1;

    logic [9:0]       shift;         // Stop, data, start.
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bits_left;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            tx_ready  <= 1'b0;
            shift     <= '1;
            cnt       <= '0;
            bits_left <= '0;
        end
        else if (tx_ready)
        begin
            if (tx_valid)
            begin
                tx_ready  <= 1'b0;
                shift     <= {1'b1, tx_byte, 1'b0};
                cnt       <= CNT_W'(CLKS_PER_BIT - 1);
                bits_left <= 4'd9;
            end
        end
        else if (cnt != '0)
        begin
            cnt <= cnt - 1'b1;
        end
        else if (bits_left != '0)
        begin
            shift     <= {1'b1, shift[9:1]};
            cnt       <= CNT_W'(CLKS_PER_BIT - 1);
            bits_left <= bits_left - 1'b1;
        end
        else
        begin
            tx_ready <= 1'b1;                      // Stop bit done.
        end
    end

    assign txd = shift[0];

    a_idle_high: assert property (@(posedge aclk) disable iff (!aresetn)
        tx_ready |-> txd);

endmodule

// ==== hdl/uart_frame_codec.sv ====
`timescale 1ns/1ps

module uart_frame_codec (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic [7:0]                  rx_byte,
    input  logic                        rx_strobe,
    output uart_bridge_pkg::uart_packet_t cmd_packet,
    output logic                        cmd_valid,
    input  logic                        cmd_ready,
    input  uart_bridge_pkg::uart_packet_t rsp_packet,
    input  logic                        rsp_valid,
    output logic                        rsp_ready,
    output logic [7:0]                  tx_byte,
    output logic                        tx_valid,
    input  logic                        tx_ready
);

    localparam logic [3:0] LAST_BYTE = 4'(uart_bridge_pkg::PACKET_BYTES - 1);

    logic [3:0]  rx_cnt;
    logic [3:0]  tx_idx;
    logic        tx_busy;
    logic [71:0] rsp_word;
    logic        rx_take;

    assign rx_take = rx_strobe && !cmd_valid;   // Bytes are lost while a command waits.

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            rx_cnt    <= '0;
            cmd_valid <= 1'b0;
            rsp_ready <= 1'b0;
            tx_busy   <= 1'b0;
            tx_idx    <= '0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
            begin
                cmd_valid <= 1'b0;
            end
            if (rx_take)
            begin
                if (rx_cnt == LAST_BYTE)
                begin
                    rx_cnt    <= '0;
                    cmd_valid <= 1'b1;
                end
                else
                begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
            end

            rsp_ready <= rsp_valid && !tx_busy && !rsp_ready;
            if (rsp_valid && rsp_ready)
            begin
                tx_busy <= 1'b1;
                tx_idx  <= '0;
            end
            else if (tx_valid && tx_ready)
            begin
                if (tx_idx == LAST_BYTE)
                begin
                    tx_busy <= 1'b0;
                end
                tx_idx <= tx_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (rx_take)
        begin
            cmd_packet <= {rx_byte, cmd_packet[71:8]};    // Byte 0 lands at the bottom.
        end
        if (rsp_valid && rsp_ready)
        begin
            rsp_word <= rsp_packet;
        end
    end

    assign tx_valid = tx_busy;
    assign tx_byte  = rsp_word[8*tx_idx +: 8];

endmodule

// ==== hdl/axil_uart_master.sv ====
`timescale 1ns/1ps

module axil_uart_master (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  uart_bridge_pkg::uart_packet_t cmd_packet,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    output uart_bridge_pkg::uart_packet_t rsp_packet,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output uart_bridge_pkg::axil_req_t    axil_req,
    input  uart_bridge_pkg::axil_resp_t   axil_resp
);

    typedef enum logic [3:0]
    {
        IDLE_AXIS_SLV,
        HAND_AXIS_SLV,
        IDLE_AXIL_WR,
        RESP_AXIL_WR,
        HAND_AXIL_WR,
        IDLE_AXIL_RD,
        RESP_AXIL_RD,
        HAND_AXIL_RD,
        IDLE_AXIS_MSTR,
        HAND_AXIS_MSTR
    } state_t;

    state_t                        state;
    uart_bridge_pkg::uart_packet_t cmd_q;
    logic                          aw_done;
    logic                          w_done;

    // Either channel may be accepted first.
    assign aw_done = axil_resp.awready || !axil_req.awvalid;
    assign w_done  = axil_resp.wready || !axil_req.wvalid;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state      <= IDLE_AXIS_SLV;
            cmd_ready  <= 1'b0;
            cmd_q      <= '0;
            rsp_packet <= '0;
            rsp_valid  <= 1'b0;
            axil_req   <= '0;
        end
        else
        begin
            case (state)
                IDLE_AXIS_SLV:
                begin
                    if (cmd_valid)
                    begin
                        state     <= HAND_AXIS_SLV;
                        cmd_q     <= cmd_packet;
                        cmd_ready <= 1'b1;
                    end
                end
                HAND_AXIS_SLV:
                begin
                    case (cmd_q.opcode)
                        uart_bridge_pkg::OPCODE_WR: state <= IDLE_AXIL_WR;
                        uart_bridge_pkg::OPCODE_RD: state <= IDLE_AXIL_RD;
                        default:                    state <= IDLE_AXIS_SLV; // Silently dropped.
                    endcase
                    cmd_ready <= 1'b0;
                end
                IDLE_AXIL_WR:
                begin
                    state            <= RESP_AXIL_WR;
                    axil_req.awaddr  <= cmd_q.addr;
                    axil_req.awvalid <= 1'b1;
                    axil_req.wdata   <= cmd_q.data;
                    axil_req.wstrb   <= 4'hF;
                    axil_req.wvalid  <= 1'b1;
                end
                RESP_AXIL_WR:
                begin
                    if (axil_resp.awready)
                    begin
                        axil_req.awvalid <= 1'b0;
                    end
                    if (axil_resp.wready)
                    begin
                        axil_req.wvalid <= 1'b0;
                    end
                    if (aw_done && w_done)
                    begin
                        state           <= HAND_AXIL_WR;
                        axil_req.bready <= 1'b1;
                    end
                end
                HAND_AXIL_WR:
                begin
                    if (axil_resp.bvalid)
                    begin
                        state             <= IDLE_AXIS_MSTR;
                        axil_req.bready   <= 1'b0;
                        rsp_packet.data   <= cmd_q.data;      // Write echo.
                        rsp_packet.addr   <= cmd_q.addr;
                        rsp_packet.opcode <= uart_bridge_pkg::OPCODE_WR;
                        rsp_packet.status <= (axil_resp.bresp == uart_bridge_pkg::RESP_OKAY) ?
                            uart_bridge_pkg::STATUS_OK : uart_bridge_pkg::STATUS_ERR;
                    end
                end
                IDLE_AXIL_RD:
                begin
                    state            <= RESP_AXIL_RD;
                    axil_req.araddr  <= cmd_q.addr;
                    axil_req.arvalid <= 1'b1;
                end
                RESP_AXIL_RD:
                begin
                    if (axil_resp.arready)
                    begin
                        state            <= HAND_AXIL_RD;
                        axil_req.arvalid <= 1'b0;
                        axil_req.rready  <= 1'b1;
                    end
                end
                HAND_AXIL_RD:
                begin
                    if (axil_resp.rvalid)
                    begin
                        state             <= IDLE_AXIS_MSTR;
                        axil_req.rready   <= 1'b0;
                        rsp_packet.data   <= axil_resp.rdata;
                        rsp_packet.addr   <= cmd_q.addr;
                        rsp_packet.opcode <= uart_bridge_pkg::OPCODE_RD;
                        rsp_packet.status <= (axil_resp.rresp == uart_bridge_pkg::RESP_OKAY) ?
                            uart_bridge_pkg::STATUS_OK : uart_bridge_pkg::STATUS_ERR;
                    end
                end
                IDLE_AXIS_MSTR:
                begin
                    state     <= HAND_AXIS_MSTR;
                    rsp_valid <= 1'b1;
                end
                HAND_AXIS_MSTR:
                begin
                    if (rsp_ready)
                    begin
                        state     <= IDLE_AXIS_SLV;
                        rsp_valid <= 1'b0;
                    end
                end
                default:
                begin
                    state <= IDLE_AXIS_SLV;
                end
            endcase
        end
    end

    a_b_expected: assert property (@(posedge aclk) disable iff (!aresetn)
        axil_resp.bvalid |-> axil_req.bready);

endmodule

// ==== hdl/axil_addr_decoder.sv ====
`timescale 1ns/1ps

module axil_addr_decoder #(
    parameter int N_BANKS = 4,
    localparam int SEL_W  = (N_BANKS > 1) ? $clog2(N_BANKS) : 1
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  uart_bridge_pkg::axil_req_t axil_req,
    output uart_bridge_pkg::axil_req_t bank_req [N_BANKS],
    output logic [SEL_W-1:0]           wr_sel,
    output logic [SEL_W-1:0]           rd_sel,
    output logic                       wr_unmapped,
    output logic                       rd_unmapped
);

    localparam int BW = 32 - uart_bridge_pkg::BANK_SPAN_BITS;

    logic [BW-1:0]    aw_bank;
    logic [BW-1:0]    ar_bank;
    logic             aw_hit;
    logic             ar_hit;
    logic [SEL_W-1:0] w_route;
    logic             w_hit;

    assign aw_bank = axil_req.awaddr[31:uart_bridge_pkg::BANK_SPAN_BITS];
    assign ar_bank = axil_req.araddr[31:uart_bridge_pkg::BANK_SPAN_BITS];
    assign aw_hit  = aw_bank < BW'(N_BANKS);
    assign ar_hit  = ar_bank < BW'(N_BANKS);

    // W follows the live AW address, or the stored one once AW is gone.
    assign w_route = axil_req.awvalid ? aw_bank[SEL_W-1:0] : wr_sel;
    assign w_hit   = axil_req.awvalid ? aw_hit : !wr_unmapped;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_sel      <= '0;
            rd_sel      <= '0;
            wr_unmapped <= 1'b0;
            rd_unmapped <= 1'b0;
        end
        else
        begin
            if (axil_req.awvalid)
            begin
                wr_sel      <= aw_bank[SEL_W-1:0];
                wr_unmapped <= !aw_hit;
            end
            if (axil_req.arvalid)
            begin
                rd_sel      <= ar_bank[SEL_W-1:0];
                rd_unmapped <= !ar_hit;
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < N_BANKS; i++)
        begin
            bank_req[i]         = axil_req;
            bank_req[i].awvalid = axil_req.awvalid && aw_hit && aw_bank[SEL_W-1:0] == SEL_W'(i);
            bank_req[i].wvalid  = axil_req.wvalid && w_hit && w_route == SEL_W'(i);
            bank_req[i].bready  = axil_req.bready && !wr_unmapped && wr_sel == SEL_W'(i);
            bank_req[i].arvalid = axil_req.arvalid && ar_hit && ar_bank[SEL_W-1:0] == SEL_W'(i);
            bank_req[i].rready  = axil_req.rready && !rd_unmapped && rd_sel == SEL_W'(i);
        end
    end

endmodule

// ==== hdl/axil_resp_mux.sv ====
`timescale 1ns/1ps

module axil_resp_mux #(
    parameter int N_BANKS = 4,
    localparam int SEL_W  = (N_BANKS > 1) ? $clog2(N_BANKS) : 1
) (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  uart_bridge_pkg::axil_resp_t bank_resp [N_BANKS],
    input  logic [SEL_W-1:0]            wr_sel,
    input  logic [SEL_W-1:0]            rd_sel,
    input  logic                        wr_unmapped,
    input  logic                        rd_unmapped,
    input  uart_bridge_pkg::axil_req_t  axil_req,
    output uart_bridge_pkg::axil_resp_t axil_resp
);

    logic aw_seen;       // Selection from the decoder is current.
    logic ar_seen;
    logic err_wready;
    logic err_bvalid;
    logic err_arready;
    logic err_rvalid;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            aw_seen     <= 1'b0;
            ar_seen     <= 1'b0;
            err_wready  <= 1'b0;
            err_bvalid  <= 1'b0;
            err_arready <= 1'b0;
            err_rvalid  <= 1'b0;
        end
        else
        begin
            aw_seen     <= axil_req.awvalid;
            ar_seen     <= axil_req.arvalid;
            err_wready  <= axil_req.awvalid && axil_req.wvalid && aw_seen && wr_unmapped
                           && !err_wready && !err_bvalid;
            err_arready <= axil_req.arvalid && ar_seen && rd_unmapped
                           && !err_arready && !err_rvalid;
            if (err_wready)
            begin
                err_bvalid <= 1'b1;
            end
            else if (axil_req.bready)
            begin
                err_bvalid <= 1'b0;
            end
            if (err_arready)
            begin
                err_rvalid <= 1'b1;
            end
            else if (axil_req.rready)
            begin
                err_rvalid <= 1'b0;
            end
        end
    end

    always_comb
    begin
        axil_resp         = bank_resp[wr_sel];
        axil_resp.arready = bank_resp[rd_sel].arready;
        axil_resp.rvalid  = bank_resp[rd_sel].rvalid;
        axil_resp.rdata   = bank_resp[rd_sel].rdata;
        axil_resp.rresp   = bank_resp[rd_sel].rresp;
        if (wr_unmapped)
        begin
            axil_resp.awready = err_wready;
            axil_resp.wready  = err_wready;
            axil_resp.bvalid  = err_bvalid;
            axil_resp.bresp   = uart_bridge_pkg::RESP_SLVERR;
        end
        if (rd_unmapped)
        begin
            axil_resp.arready = err_arready;
            axil_resp.rvalid  = err_rvalid;
            axil_resp.rdata   = '0;
            axil_resp.rresp   = uart_bridge_pkg::RESP_SLVERR;
        end
    end

endmodule

// ==== hdl/axil_reg_bank.sv ====
`timescale 1ns/1ps

module axil_reg_bank #(
    parameter int REGS_PER_BANK = 8
) (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  uart_bridge_pkg::axil_req_t  axil_req,
    output uart_bridge_pkg::axil_resp_t axil_resp
);

    localparam int IDX_W  = uart_bridge_pkg::BANK_SPAN_BITS - 2;
    localparam int RIDX_W = (REGS_PER_BANK > 1) ? $clog2(REGS_PER_BANK) : 1;

    logic [31:0]      regs [REGS_PER_BANK];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_hit;
    logic             rd_hit;
    logic             wr_start;
    logic             wr_accept;
    logic             rd_start;
    logic             rd_accept;

    assign wr_idx    = axil_req.awaddr[uart_bridge_pkg::BANK_SPAN_BITS-1:2];
    assign rd_idx    = axil_req.araddr[uart_bridge_pkg::BANK_SPAN_BITS-1:2];
    assign wr_hit    = int'(wr_idx) < REGS_PER_BANK;
    assign rd_hit    = int'(rd_idx) < REGS_PER_BANK;
    assign wr_start  = axil_req.awvalid && axil_req.wvalid && !axil_resp.awready
                       && !axil_resp.bvalid;
    assign wr_accept = axil_req.awvalid && axil_resp.awready
                       && axil_req.wvalid && axil_resp.wready;
    assign rd_start  = axil_req.arvalid && !axil_resp.arready && !axil_resp.rvalid;
    assign rd_accept = axil_req.arvalid && axil_resp.arready;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            axil_resp <= '0;
            for (int i = 0; i < REGS_PER_BANK; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            axil_resp.awready <= wr_start;         // AW and W taken together.
            axil_resp.wready  <= wr_start;
            axil_resp.arready <= rd_start;
            if (wr_accept)
            begin
                axil_resp.bvalid <= 1'b1;
                axil_resp.bresp  <= wr_hit ? uart_bridge_pkg::RESP_OKAY
                                           : uart_bridge_pkg::RESP_SLVERR;
                if (wr_hit)
                begin
                    regs[wr_idx[RIDX_W-1:0]] <= axil_req.wdata;
                end
            end
            else if (axil_req.bready)
            begin
                axil_resp.bvalid <= 1'b0;
            end
            if (rd_accept)
            begin
                axil_resp.rvalid <= 1'b1;
                axil_resp.rdata  <= rd_hit ? regs[rd_idx[RIDX_W-1:0]] : '0;
                axil_resp.rresp  <= rd_hit ? uart_bridge_pkg::RESP_OKAY
                                           : uart_bridge_pkg::RESP_SLVERR;
            end
            else if (axil_req.rready)
            begin
                axil_resp.rvalid <= 1'b0;
            end
        end
    end

    a_valid_held: assert property (@(posedge aclk) disable iff (!aresetn)
        axil_resp.awready |-> axil_req.awvalid && axil_req.wvalid);

endmodule

// ==== hdl/uart_axil_bridge_top.sv ====
`timescale 1ns/1ps

module uart_axil_bridge_top #(
    parameter int N_BANKS       = 4,
    parameter int REGS_PER_BANK = 8,
    parameter int CLKS_PER_BIT  = 8
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic rxd,
    output logic txd
);

    localparam int SEL_W = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;

    logic [7:0]                    rx_byte;
    logic                          rx_strobe;
    logic [7:0]                    tx_byte;
    logic                          tx_valid;
    logic                          tx_ready;
    uart_bridge_pkg::uart_packet_t cmd_packet;
    logic                          cmd_valid;
    logic                          cmd_ready;
    uart_bridge_pkg::uart_packet_t rsp_packet;
    logic                          rsp_valid;
    logic                          rsp_ready;
    uart_bridge_pkg::axil_req_t    axil_req;
    uart_bridge_pkg::axil_resp_t   axil_resp;
    uart_bridge_pkg::axil_req_t    bank_req  [N_BANKS];
    uart_bridge_pkg::axil_resp_t   bank_resp [N_BANKS];
    logic [SEL_W-1:0]              wr_sel;
    logic [SEL_W-1:0]              rd_sel;
    logic                          wr_unmapped;
    logic                          rd_unmapped;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .aclk, .aresetn, .rxd, .rx_byte, .rx_strobe
    );

    uart_frame_codec u_codec (
        .aclk, .aresetn, .rx_byte, .rx_strobe,
        .cmd_packet, .cmd_valid, .cmd_ready,
        .rsp_packet, .rsp_valid, .rsp_ready,
        .tx_byte, .tx_valid, .tx_ready
    );

    axil_uart_master u_master (
        .aclk, .aresetn, .cmd_packet, .cmd_valid, .cmd_ready,
        .rsp_packet, .rsp_valid, .rsp_ready, .axil_req, .axil_resp
    );

    axil_addr_decoder #(.N_BANKS(N_BANKS)) u_decoder (
        .aclk, .aresetn, .axil_req, .bank_req,
        .wr_sel, .rd_sel, .wr_unmapped, .rd_unmapped
    );

    for (genvar g = 0; g < N_BANKS; g++)
    begin : g_bank
        axil_reg_bank #(.REGS_PER_BANK(REGS_PER_BANK)) u_bank (
            .aclk, .aresetn, .axil_req(bank_req[g]), .axil_resp(bank_resp[g])
        );
    end

    axil_resp_mux #(.N_BANKS(N_BANKS)) u_resp_mux (
        .aclk, .aresetn, .bank_resp, .wr_sel, .rd_sel,
        .wr_unmapped, .rd_unmapped, .axil_req, .axil_resp
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .aclk, .aresetn, .tx_byte, .tx_valid, .tx_ready, .txd
    );

endmodule

// ==== bench/tb_uart_tasks.svh ====
function automatic logic [71:0] build_frame(input logic [3:0] op, input logic [31:0] addr,
                                            input logic [31:0] data);
    logic [71:0] frame;
    frame[7:0] = {op, ST_OK};
    for (int k = 0; k < 4; k++)
    begin
        frame[8 + 8*k +: 8]  = addr[8*k +: 8];     // Address, LSB first.
        frame[40 + 8*k +: 8] = data[8*k +: 8];
    end
    return frame;
endfunction

task automatic send_byte(input logic [7:0] b);
    @(posedge aclk);
    rxd <= 1'b0;
    repeat (CLKS_PER_BIT) @(posedge aclk);
    for (int i = 0; i < 8; i++)
    begin
        rxd <= b[i];
        repeat (CLKS_PER_BIT) @(posedge aclk);
    end
    rxd <= 1'b1;                                   // Stop bit.
    repeat (CLKS_PER_BIT) @(posedge aclk);
endtask

task automatic send_frame(input logic [71:0] frame);
    for (int k = 0; k < PACKET_BYTES; k++)
    begin
        send_byte(frame[8*k +: 8]);
    end
endtask

task automatic receive_byte(output logic [7:0] b, output bit ok, input int wait_cycles);
    int n;
    n  = 0;
    ok = 1'b0;
    b  = '0;
    while (!ok && n < wait_cycles)
    begin
        @(negedge aclk);
        ok = (txd === 1'b0);
        n++;
    end
    if (ok)
    begin
        repeat (CLKS_PER_BIT / 2) @(negedge aclk);  // Middle of the start bit.
        assert (txd === 1'b0) else
        begin
            other_errors++;
            $display("Start bit on txd ended early at %0t ns", $time);
        end
        for (int i = 0; i < 8; i++)
        begin
            repeat (CLKS_PER_BIT) @(negedge aclk);
            b[i] = txd;
        end
        repeat (CLKS_PER_BIT) @(negedge aclk);
        assert (txd === 1'b1) else
        begin
            other_errors++;
            $display("Stop bit on txd is missing at %0t ns", $time);
        end
    end
endtask

task automatic receive_frame(output logic [71:0] frame, output bit got, input int first_wait);
    logic [7:0] b;
    bit         ok;
    int         wait_cycles;
    got         = 1'b1;
    frame       = '0;
    wait_cycles = first_wait;
    for (int k = 0; k < PACKET_BYTES && got; k++)
    begin
        receive_byte(b, ok, wait_cycles);
        frame[8*k +: 8] = b;
        got             = ok;
        wait_cycles     = BYTE_WAIT;
    end
endtask

task automatic expect_equal(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected) else
    begin
        mismatches++;
        $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
endtask

task automatic run_command(input logic [3:0] op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp_data,
                           input logic [3:0] exp_status);
    logic [71:0] rsp;
    bit          got;
    send_frame(build_frame(op, addr, wdata));
    receive_frame(rsp, got, RSP_WAIT);
    assert (got) else
    begin
        other_errors++;
        $display("No response frame for opcode %h at address %h, time %0t ns", op, addr, $time);
    end
    if (got)
    begin
        expect_equal("response opcode", 32'(rsp[7:4]), 32'(op));
        expect_equal("response status", 32'(rsp[3:0]), 32'(exp_status));
        expect_equal("response address", rsp[39:8], addr);
        expect_equal("response data", rsp[71:40], exp_data);
    end
endtask

task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] exp_status);
    run_command(OP_WRITE, addr, data, data, exp_status);   // Data is echoed.
endtask

task automatic do_read(input logic [31:0] addr, input logic [31:0] exp_data,
                       input logic [3:0] exp_status);
    run_command(OP_READ, addr, 32'h0, exp_data, exp_status);
endtask

// ==== bench/tb_uart_axil_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_axil_bridge;

    localparam int N_BANKS         = 4;
    localparam int REGS_PER_BANK   = 8;
    localparam int CLKS_PER_BIT    = 8;
    localparam int PACKET_BYTES    = 9;
    localparam int FRAME_CYCLES    = PACKET_BYTES * 10 * CLKS_PER_BIT;
    localparam int RSP_WAIT        = 2 * FRAME_CYCLES;
    localparam int BYTE_WAIT       = 3 * 10 * CLKS_PER_BIT;
    localparam int N_FRAMES        = 48;   // 22 commands with responses, plus idle windows.
    localparam int WATCHDOG_CYCLES = 2 * N_FRAMES * FRAME_CYCLES + 64;

    localparam logic [3:0] OP_WRITE = 4'hA;
    localparam logic [3:0] OP_READ  = 4'h5;
    localparam logic [3:0] OP_BAD   = 4'h3;
    localparam logic [3:0] ST_OK    = 4'h0;
    localparam logic [3:0] ST_ERR   = 4'hF;

    logic        aclk;
    logic        aresetn;
    logic        rxd;
    logic        txd;
    int          seed;
    int          mismatches;
    int          other_errors;
    logic [31:0] bank_vals [N_BANKS];

    uart_axil_bridge_top #(
        .N_BANKS(N_BANKS),
        .REGS_PER_BANK(REGS_PER_BANK),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_dut (
        .aclk, .aresetn, .rxd, .txd
    );

    `include "tb_uart_tasks.svh"

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    task automatic read_reset_values();
        for (int b = 0; b < N_BANKS; b++)
        begin
            do_read(32'(b * 256 + (2 * b + 1) * 4), 32'h0, ST_OK);
        end
    endtask

    task automatic write_read_round_trip();
        logic [31:0] d0;
        logic [31:0] d1;
        d0 = $random(seed);
        d1 = $random(seed);
        do_write(32'h0000_0204, d0, ST_OK);        // Bank 2, register 1.
        do_read(32'h0000_0204, d0, ST_OK);
        do_write(32'h0000_031C, d1, ST_OK);        // Bank 3, last register.
        do_read(32'h0000_031C, d1, ST_OK);
    endtask

    task automatic verify_bank_isolation();
        for (int b = 0; b < N_BANKS; b++)
        begin
            bank_vals[b] = {8'(b), 24'($random(seed))};   // Top byte keeps them distinct.
            do_write(32'(b * 256), bank_vals[b], ST_OK);
        end
        for (int b = 0; b < N_BANKS; b++)
        begin
            do_read(32'(b * 256), bank_vals[b], ST_OK);
        end
    endtask

    task automatic provoke_error_responses();
        logic [31:0] junk;
        junk = $random(seed);
        do_write(32'(N_BANKS * 256), junk, ST_ERR);
        do_read(32'(N_BANKS * 256), 32'h0, ST_ERR);
        do_write(32'(256 + REGS_PER_BANK * 4), junk, ST_ERR);
        do_read(32'(256 + REGS_PER_BANK * 4), 32'h0, ST_ERR);
        do_read(32'h0000_0100, bank_vals[1], ST_OK);   // Register 0 would alias index 8.
    endtask

    task automatic ignore_unknown_opcode();
        logic [71:0] rsp;
        bit          got;
        send_frame(build_frame(OP_BAD, 32'h0000_0000, 32'hDEAD_BEEF));
        receive_frame(rsp, got, RSP_WAIT);
        assert (!got) else
        begin
            other_errors++;
            $display("Unexpected response frame to an unknown opcode at %0t ns", $time);
        end
        do_read(32'h0000_0200, bank_vals[2], ST_OK);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        seed         = 75;
        mismatches   = 0;
        other_errors = 0;
        aresetn      = 1'b0;
        rxd          = 1'b1;                       // Line idles high.
        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (4) @(posedge aclk);

        read_reset_values();
        write_read_round_trip();
        verify_bank_isolation();
        provoke_error_responses();
        ignore_unknown_opcode();

        $display("Run complete with %0d mismatches and %0d other errors",
                 mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+bench
hdl/uart_bridge_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_frame_codec.sv
hdl/axil_uart_master.sv
hdl/axil_addr_decoder.sv
hdl/axil_resp_mux.sv
hdl/axil_reg_bank.sv
hdl/uart_axil_bridge_top.sv
bench/tb_uart_axil_bridge.sv

// ==== Makefile ====
# Verilator build and run of the UART to AXI-Lite bridge testbench.

VERILATOR ?= verilator
TOP       ?= tb_uart_axil_bridge
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hdl/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
